// File: flist.f
source/pi1_pkg.sv
source/pi1_byte_addr.sv
source/pi1_downconverter.sv
source/pi1_sram_slave.sv
source/pi1_bridge_top.sv
verification/pi1_downconverter_chk.sv
verification/pi1_bridge_tb.sv

// File: Makefile
# Verilator build and run for the PI1 bridge

VERILATOR ?= verilator
TOP       ?= pi1_bridge_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/10ps
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert
EXTRA     ?=

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FLIST BUILD_DIR TIMESCALE JOBS VFLAGS EXTRA"

$(SIM_BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) \
		--timescale $(TIMESCALE) \
		-j $(JOBS) \
		--top-module $(TOP) \
		-Mdir $(BUILD_DIR) \
		-f $(FLIST) \
		$(EXTRA)

# exit status of the simulation is the test result
test: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)

// File: verification/pi1_bridge_tb.sv
// ========================================
// directed tests for the PI1 bridge top
// reference memory model, LFSR and watchdog
// ========================================

`timescale 1ns/10ps
`default_nettype none

module pi1_bridge_tb
	import pi1_pkg::*;
;

	// fill 256, lanes 16, partial 6, swap 4, overlap 4, random 200
	localparam int PLANNED_OPS     = 256 + 16 + 6 + 4 + 4 + 200;
	localparam int WATCHDOG_CYCLES = PLANNED_OPS * 40 + 10;

	logic                      clk_i;
	logic                      rst_n_i;
	logic [PI1_OPBITSZ-1:0]    m_pi1_op_i;
	logic [PI1_MADDRBITSZ-1:0] m_pi1_addr_i;
	logic [PI1_MARCHBITSZ-1:0] m_pi1_data_i;
	logic [PI1_MSELBITSZ-1:0]  m_pi1_sel_i;
	logic [PI1_MARCHBITSZ-1:0] m_pi1_data_o;
	logic                      m_pi1_rdy_o;
	logic [PI1_MARCHBITSZ-1:0] m_pi1_mapsz_o;

	logic [7:0]  ref_mem [PI1_MEM_BYTES]; // byte-wide reference model
	logic [31:0] lfsr_q = 32'hedb6_7061;

	pi1_bridge_top u_pi1_bridge_top (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.m_pi1_op_i    (m_pi1_op_i),
		.m_pi1_addr_i  (m_pi1_addr_i),
		.m_pi1_data_i  (m_pi1_data_i),
		.m_pi1_sel_i   (m_pi1_sel_i),
		.m_pi1_data_o  (m_pi1_data_o),
		.m_pi1_rdy_o   (m_pi1_rdy_o),
		.m_pi1_mapsz_o (m_pi1_mapsz_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_i);
		$display("timeout: the bus operations did not finish in the allowed time");
		$display("Simulation failed");
		$fatal(1, "watchdog expired");
	end

	// ========================================
	// helpers
	// ========================================
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // x^32+x^22+x^2+x+1
	endfunction

	task automatic rand_bits(input int n, output logic [63:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[62:0], lfsr_q[0]};
		end
	endtask

	task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
		if (got !== exp) begin
			$display("error at %0t: %s, got %h expected %h", $time, msg, got, exp);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic next_cycle;
		@(posedge clk_i);
		#0.5;
	endtask

	task automatic wait_ready;
		while (!m_pi1_rdy_o)
			next_cycle();
	endtask

	function automatic int lane_of(input logic [7:0] sel);
		for (int i = 0; i < 8; i++) begin
			if (sel[i])
				return i / 4;
		end
		return 0;
	endfunction

	function automatic int byte_base(input logic [PI1_MADDRBITSZ-1:0] addr, input logic [7:0] sel);
		return int'(addr[6:0]) * 8 + lane_of(sel) * 4;
	endfunction

	task automatic model_write(input logic [PI1_MADDRBITSZ-1:0] addr, input logic [63:0] data,
			input logic [7:0] sel);
		int lane;
		int base;
		lane = lane_of(sel);
		base = byte_base(addr, sel);
		for (int b = 0; b < 4; b++) begin
			if (sel[lane*4 + b])
				ref_mem[base + b] = data[(lane*4 + b)*8 +: 8];
		end
	endtask

	// expected read data, addressed word in its lane, other lane zero
	function automatic logic [63:0] model_word(input logic [PI1_MADDRBITSZ-1:0] addr,
			input logic [7:0] sel);
		logic [63:0] v;
		int lane;
		int base;
		v = '0;
		lane = lane_of(sel);
		base = byte_base(addr, sel);
		for (int b = 0; b < 4; b++)
			v[(lane*4 + b)*8 +: 8] = ref_mem[base + b];
		return v;
	endfunction

	task automatic bus_cycle(input logic [PI1_OPBITSZ-1:0] op,
			input logic [PI1_MADDRBITSZ-1:0] addr, input logic [63:0] data,
			input logic [7:0] sel, output logic [63:0] rdata, output int low_cycles);
		wait_ready();
		m_pi1_op_i   = op;
		m_pi1_addr_i = addr;
		m_pi1_data_i = data;
		m_pi1_sel_i  = sel;
		next_cycle(); // accepting edge
		m_pi1_op_i = PI1_OP_NOP;
		low_cycles = 0;
		while (!m_pi1_rdy_o) begin
			low_cycles++;
			next_cycle();
		end
		rdata = m_pi1_data_o;
	endtask

	task automatic bus_write(input logic [PI1_MADDRBITSZ-1:0] addr, input logic [63:0] data,
			input logic [7:0] sel);
		logic [63:0] rdata;
		int low;
		bus_cycle(PI1_OP_WR, addr, data, sel, rdata, low);
		check(64'(low), 64'd0, "write stalled the bus");
		model_write(addr, data, sel);
	endtask

	task automatic bus_read(input logic [PI1_MADDRBITSZ-1:0] addr, input logic [7:0] sel);
		logic [63:0] rdata;
		int low;
		bus_cycle(PI1_OP_RD, addr, 64'd0, sel, rdata, low);
		check(rdata, model_word(addr, sel), $sformatf("read word %0d sel %h", addr, sel));
	endtask

	task automatic bus_swap(input logic [PI1_MADDRBITSZ-1:0] addr, input logic [63:0] data,
			input logic [7:0] sel);
		logic [63:0] rdata;
		logic [63:0] old;
		int low;
		old = model_word(addr, sel);
		bus_cycle(PI1_OP_RW, addr, data, sel, rdata, low);
		check(64'(low), 64'd1, "swap ready-low cycles");
		check(rdata, old, $sformatf("swap old word %0d", addr));
		model_write(addr, data, sel);
	endtask

	// ========================================
	// tests
	// ========================================
	task automatic reset_values;
		check(64'(m_pi1_rdy_o), 64'd1, "ready after reset");
		check(m_pi1_mapsz_o, 64'(PI1_MEM_BYTES), "mapped size");
		check(m_pi1_data_o, 64'd0, "read data after reset");
	endtask

	task automatic preload_memory;
		logic [9:0]  ba;
		logic [31:0] w;
		for (int a = 0; a < 128; a++) begin
			for (int l = 0; l < 2; l++) begin
				ba = 10'(a * 8 + l * 4);
				w = {6'h2a, ba, 6'h15, ba}; // pattern from the whole byte address
				bus_write(PI1_MADDRBITSZ'(a), (l == 1) ? {w, ~w} : {~w, w},
					(l == 1) ? 8'hf0 : 8'h0f);
			end
		end
	endtask

	task automatic full_lane_rw;
		logic [63:0] d;
		int words [4] = '{0, 1, 64, 127};
		foreach (words[i]) begin
			rand_bits(64, d);
			bus_write(PI1_MADDRBITSZ'(words[i]), d, 8'h0f);
			rand_bits(64, d);
			bus_write(PI1_MADDRBITSZ'(words[i]), d, 8'hf0);
			bus_read(PI1_MADDRBITSZ'(words[i]), 8'h0f);
			bus_read(PI1_MADDRBITSZ'(words[i]), 8'hf0);
		end
	endtask

	task automatic partial_merge;
		bus_write(61'd9, 64'h1111_2222_3333_44a5, 8'h01);
		bus_write(61'd9, 64'h5555_6666_7b8c_8888, 8'h0c);
		bus_write(61'd9, 64'h99d1_aaaa_bbbb_cccc, 8'h40);
		bus_write(61'd9, 64'hfe2f_dddd_eeee_ffff, 8'hc0); // two bytes, high lane
		bus_read(61'd9, 8'h0f);
		bus_read(61'd9, 8'hf0);
	endtask

	task automatic swap_basic;
		bus_swap(61'd5, 64'h0bad_f00d_c0ff_ee01, 8'h0f);
		bus_read(61'd5, 8'h0f);
		bus_swap(61'd77, 64'h00a7_0000_0000_0000, 8'h40);
		bus_read(61'd77, 8'hf0);
	endtask

	// second swap presented while the first holds ready low
	task automatic swap_overlap;
		logic [63:0] old;
		old = model_word(61'd21, 8'hf0);
		wait_ready();
		m_pi1_op_i   = PI1_OP_RW;
		m_pi1_addr_i = 61'd21;
		m_pi1_data_i = 64'h1234_5678_0000_0000;
		m_pi1_sel_i  = 8'hf0;
		next_cycle();
		check(64'(m_pi1_rdy_o), 64'd0, "ready low after swap");
		m_pi1_data_i = 64'h00cd_ab00_ffff_ffff;
		m_pi1_sel_i  = 8'h30;
		next_cycle();
		check(64'(m_pi1_rdy_o), 64'd1, "ready back after one cycle");
		check(m_pi1_data_o, old, "first swap old word");
		model_write(61'd21, 64'h1234_5678_0000_0000, 8'hf0);
		old = model_word(61'd21, 8'h30);
		next_cycle(); // second swap taken here
		m_pi1_op_i = PI1_OP_NOP;
		check(64'(m_pi1_rdy_o), 64'd0, "second swap stalls");
		next_cycle();
		check(64'(m_pi1_rdy_o), 64'd1, "ready back after second swap");
		check(m_pi1_data_o, old, "second swap old word");
		model_write(61'd21, 64'h00cd_ab00_ffff_ffff, 8'h30);
		next_cycle();
		check(64'(m_pi1_rdy_o), 64'd1, "no third stall");
		bus_read(61'd21, 8'hf0);
	endtask

	task automatic random_traffic;
		logic [63:0]               r;
		logic [63:0]               d;
		logic [PI1_MADDRBITSZ-1:0] a;
		logic [3:0]                nib;
		logic                      is_wr;
		logic                      lane;
		for (int n = 0; n < 200; n++) begin
			rand_bits(1, r);
			is_wr = r[0];
			rand_bits(7, r);
			a = PI1_MADDRBITSZ'(r[6:0]);
			rand_bits(1, r);
			lane = r[0];
			rand_bits(4, r);
			nib = (r[3:0] == 4'h0) ? 4'h1 : r[3:0];
			rand_bits(64, d);
			if (is_wr)
				bus_write(a, d, lane ? {nib, 4'h0} : {4'h0, nib});
			else
				bus_read(a, lane ? 8'hf0 : 8'h0f);
		end
	endtask

	// ========================================
	// main sequence
	// ========================================
	initial begin
		rst_n_i      = 1'b0;
		m_pi1_op_i   = PI1_OP_NOP;
		m_pi1_addr_i = '0;
		m_pi1_data_i = '0;
		m_pi1_sel_i  = '0;
		repeat (10) @(posedge clk_i);
		#0.5;
		rst_n_i = 1'b1;
		reset_values();
		preload_memory();
		full_lane_rw();
		partial_merge();
		swap_basic();
		swap_overlap();
		random_traffic();
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/pi1_downconverter_chk.sv
// ========================================
// bound assertions on the PI1 downconverter
// ========================================

`timescale 1ns/10ps
`default_nettype none

module pi1_downconverter_chk
	import pi1_pkg::*;
(
	input wire logic                      clk_i,
	input wire logic                      rst_n_i,
	input wire logic [PI1_OPBITSZ-1:0]    m_pi1_op_i,
	input wire logic [PI1_OPBITSZ-1:0]    s_pi1_op_o,
	input wire logic                      m_pi1_rdy_o,
	input wire logic                      s_pi1_rdy_i,
	input wire logic [PI1_MARCHBITSZ-1:0] m_pi1_mapsz_o,
	input wire logic [PI1_SARCHBITSZ-1:0] s_pi1_mapsz_i,
	input wire logic [PI1_MARCHBITSZ-1:0] m_pi1_data_o,
	input wire logic [PI1_SADDRBITSZ-1:0] s_pi1_addr_o
);

	logic hold_lane_q; // lane of the last ready edge

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			hold_lane_q <= 1'b0;
		else if (s_pi1_rdy_i)
			hold_lane_q <= s_pi1_addr_o[0];
	end

	op_pass: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		s_pi1_op_o == m_pi1_op_i)
		else $error("op not forwarded to the slave side");

	rdy_pass: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		m_pi1_rdy_o == s_pi1_rdy_i)
		else $error("ready not forwarded to the master side");

	mapsz_pass: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		m_pi1_mapsz_o == PI1_MARCHBITSZ'(s_pi1_mapsz_i))
		else $error("mapped size not forwarded to the master side");

	// unused lane of the read data must stay zero
	idle_lane_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		hold_lane_q ? (m_pi1_data_o[PI1_SARCHBITSZ-1:0] == '0)
			: (m_pi1_data_o[PI1_MARCHBITSZ-1:PI1_SARCHBITSZ] == '0))
		else $error("read data present in the unselected lane");

endmodule

bind pi1_downconverter pi1_downconverter_chk u_pi1_downconverter_chk (
	.clk_i         (clk_i),
	.rst_n_i       (rst_n_i),
	.m_pi1_op_i    (m_pi1_op_i),
	.s_pi1_op_o    (s_pi1_op_o),
	.m_pi1_rdy_o   (m_pi1_rdy_o),
	.s_pi1_rdy_i   (s_pi1_rdy_i),
	.m_pi1_mapsz_o (m_pi1_mapsz_o),
	.s_pi1_mapsz_i (s_pi1_mapsz_i),
	.m_pi1_data_o  (m_pi1_data_o),
	.s_pi1_addr_o  (s_pi1_addr_o)
);

`default_nettype wire

// File: source/pi1_bridge_top.sv
// ========================================
// downconverter plus memory slave
// ========================================

`timescale 1ns/10ps
`default_nettype none

module pi1_bridge_top
	import pi1_pkg::*;
(
	input  wire logic                      clk_i,
	input  wire logic                      rst_n_i,

	input  wire logic [PI1_OPBITSZ-1:0]    m_pi1_op_i,
	input  wire logic [PI1_MADDRBITSZ-1:0] m_pi1_addr_i,
	input  wire logic [PI1_MARCHBITSZ-1:0] m_pi1_data_i,
	input  wire logic [PI1_MSELBITSZ-1:0]  m_pi1_sel_i,
	output logic      [PI1_MARCHBITSZ-1:0] m_pi1_data_o,
	output logic                           m_pi1_rdy_o,
	output logic      [PI1_MARCHBITSZ-1:0] m_pi1_mapsz_o
);

	// ========================================
	// 32-bit slave bus
	// ========================================
	logic [PI1_OPBITSZ-1:0]    s_pi1_op;
	logic [PI1_SADDRBITSZ-1:0] s_pi1_addr;
	logic [PI1_SARCHBITSZ-1:0] s_pi1_data_w; // write data
	logic [PI1_SARCHBITSZ-1:0] s_pi1_data_r; // read data
	logic [PI1_SSELBITSZ-1:0]  s_pi1_sel;
	logic                      s_pi1_rdy;
	logic [PI1_SARCHBITSZ-1:0] s_pi1_mapsz;

	pi1_downconverter u_pi1_downconverter (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.m_pi1_op_i    (m_pi1_op_i),
		.m_pi1_addr_i  (m_pi1_addr_i),
		.m_pi1_data_i  (m_pi1_data_i),
		.m_pi1_sel_i   (m_pi1_sel_i),
		.m_pi1_data_o  (m_pi1_data_o),
		.m_pi1_rdy_o   (m_pi1_rdy_o),
		.m_pi1_mapsz_o (m_pi1_mapsz_o),
		.s_pi1_op_o    (s_pi1_op),
		.s_pi1_addr_o  (s_pi1_addr),
		.s_pi1_data_o  (s_pi1_data_w),
		.s_pi1_data_i  (s_pi1_data_r),
		.s_pi1_sel_o   (s_pi1_sel),
		.s_pi1_rdy_i   (s_pi1_rdy),
		.s_pi1_mapsz_i (s_pi1_mapsz)
	);

	pi1_sram_slave u_pi1_sram_slave (
		.clk_i         (clk_i),
		.rst_n_i       (rst_n_i),
		.s_pi1_op_i    (s_pi1_op),
		.s_pi1_addr_i  (s_pi1_addr),
		.s_pi1_data_i  (s_pi1_data_w),
		.s_pi1_sel_i   (s_pi1_sel),
		.s_pi1_data_o  (s_pi1_data_r),
		.s_pi1_rdy_o   (s_pi1_rdy),
		.s_pi1_mapsz_o (s_pi1_mapsz)
	);

endmodule

`default_nettype wire

// File: source/pi1_sram_slave.sv
// ========================================
// 32-bit PI1 slave memory, byte selects and swap
// ========================================

`timescale 1ns/10ps
`default_nettype none

module pi1_sram_slave
	import pi1_pkg::*;
(
	input  wire logic                      clk_i,
	input  wire logic                      rst_n_i,

	input  wire logic [PI1_OPBITSZ-1:0]    s_pi1_op_i,
	input  wire logic [PI1_SADDRBITSZ-1:0] s_pi1_addr_i,
	input  wire logic [PI1_SARCHBITSZ-1:0] s_pi1_data_i,
	input  wire logic [PI1_SSELBITSZ-1:0]  s_pi1_sel_i,
	output logic      [PI1_SARCHBITSZ-1:0] s_pi1_data_o,
	output logic                           s_pi1_rdy_o,
	output logic      [PI1_SARCHBITSZ-1:0] s_pi1_mapsz_o
);

	logic [PI1_SARCHBITSZ-1:0] mem [PI1_MEM_WORDS];

	logic [PI1_MEM_ADDRBITSZ-1:0] req_idx;

	// decoded, accepted requests
	logic do_wr;
	logic do_rd;
	logic do_swap;

	// swap second phase
	logic                         swap_pend;
	logic [PI1_MEM_ADDRBITSZ-1:0] swap_idx;
	logic [PI1_SARCHBITSZ-1:0]    swap_data;
	logic [PI1_SSELBITSZ-1:0]     swap_sel;

	// shared write port
	logic                         wr_en;
	logic [PI1_MEM_ADDRBITSZ-1:0] wr_idx;
	logic [PI1_SARCHBITSZ-1:0]    wr_data;
	logic [PI1_SSELBITSZ-1:0]     wr_sel;

	assign req_idx       = s_pi1_addr_i[PI1_MEM_ADDRBITSZ-1:0];
	assign s_pi1_rdy_o   = !swap_pend;
	assign s_pi1_mapsz_o = PI1_SARCHBITSZ'(PI1_MEM_BYTES);

	// ========================================
	// request decode
	// ========================================
	always_comb begin
		do_wr   = 1'b0;
		do_rd   = 1'b0;
		do_swap = 1'b0;
		case (s_pi1_op_i)
			PI1_OP_NOP: ;
			PI1_OP_WR:  do_wr   = s_pi1_rdy_o;
			PI1_OP_RD:  do_rd   = s_pi1_rdy_o;
			PI1_OP_RW:  do_swap = s_pi1_rdy_o;
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			swap_pend <= 1'b0;
		else
			swap_pend <= do_swap; // ready low for one cycle
	end

	always_ff @(posedge clk_i) begin
		if (do_swap) begin
			swap_idx  <= req_idx;
			swap_data <= s_pi1_data_i;
			swap_sel  <= s_pi1_sel_i;
		end
	end

	// ========================================
	// memory array
	// ========================================
	assign wr_en   = do_wr || swap_pend;
	assign wr_idx  = swap_pend ? swap_idx : req_idx;
	assign wr_data = swap_pend ? swap_data : s_pi1_data_i;
	assign wr_sel  = swap_pend ? swap_sel : s_pi1_sel_i;

	always_ff @(posedge clk_i) begin
		if (wr_en) begin
			for (int b = 0; b < PI1_SSELBITSZ; b++) begin
				if (wr_sel[b])
					mem[wr_idx][b*8 +: 8] <= wr_data[b*8 +: 8];
			end
		end
	end

	// old word of a swap comes back here too
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			s_pi1_data_o <= '0;
		else if (do_rd || do_swap)
			s_pi1_data_o <= mem[req_idx];
	end

endmodule

`default_nettype wire

// File: source/pi1_downconverter.sv
// ========================================
// 64-bit PI1 master to 32-bit PI1 slave
// ========================================

`timescale 1ns/10ps
`default_nettype none

module pi1_downconverter
	import pi1_pkg::*;
(
	input  wire logic                      clk_i,
	input  wire logic                      rst_n_i,

	// master side
	input  wire logic [PI1_OPBITSZ-1:0]    m_pi1_op_i,
	input  wire logic [PI1_MADDRBITSZ-1:0] m_pi1_addr_i,
	input  wire logic [PI1_MARCHBITSZ-1:0] m_pi1_data_i,
	input  wire logic [PI1_MSELBITSZ-1:0]  m_pi1_sel_i,
	output logic      [PI1_MARCHBITSZ-1:0] m_pi1_data_o,
	output logic                           m_pi1_rdy_o,
	output logic      [PI1_MARCHBITSZ-1:0] m_pi1_mapsz_o,

	// slave side
	output logic      [PI1_OPBITSZ-1:0]    s_pi1_op_o,
	output logic      [PI1_SADDRBITSZ-1:0] s_pi1_addr_o,
	output logic      [PI1_SARCHBITSZ-1:0] s_pi1_data_o,
	input  wire logic [PI1_SARCHBITSZ-1:0] s_pi1_data_i,
	output logic      [PI1_SSELBITSZ-1:0]  s_pi1_sel_o,
	input  wire logic                      s_pi1_rdy_i,
	input  wire logic [PI1_SARCHBITSZ-1:0] s_pi1_mapsz_i
);

	assign s_pi1_op_o    = m_pi1_op_i;
	assign m_pi1_rdy_o   = s_pi1_rdy_i;
	assign m_pi1_mapsz_o = PI1_MARCHBITSZ'(s_pi1_mapsz_i);

	generate if (PI1_MARCHBITSZ > PI1_SARCHBITSZ) begin : gen_down

		logic [PI1_MARCHBITSZ-1:0] byte_addr;
		logic [PI1_SADDRBITSZ-1:0] addr_hold; // slave address of last ready edge
		logic [PI1_LANEBITSZ-1:0]  lane;
		logic [PI1_LANEBITSZ-1:0]  hold_lane;
		logic [PI1_MARCHBITSZ-1:0] wdata_shift;
		logic [PI1_MSELBITSZ-1:0]  sel_shift;

		pi1_byte_addr u_pi1_byte_addr (
			.addr_i (m_pi1_addr_i),
			.sel_i  (m_pi1_sel_i),
			.addr_o (byte_addr)
		);

		assign s_pi1_addr_o = byte_addr[PI1_SADDRBITSZ + PI1_SBYTEBITSZ - 1 : PI1_SBYTEBITSZ];

		always_ff @(posedge clk_i or negedge rst_n_i) begin
			if (!rst_n_i)
				addr_hold <= '0;
			else if (s_pi1_rdy_i)
				addr_hold <= s_pi1_addr_o;
		end

		assign lane      = s_pi1_addr_o[PI1_LANEBITSZ-1:0];
		assign hold_lane = addr_hold[PI1_LANEBITSZ-1:0];

		// request side follows the live lane
		assign wdata_shift  = m_pi1_data_i >> (lane * PI1_SARCHBITSZ);
		assign sel_shift    = m_pi1_sel_i >> (lane * PI1_SSELBITSZ);
		assign s_pi1_data_o = wdata_shift[PI1_SARCHBITSZ-1:0];
		assign s_pi1_sel_o  = sel_shift[PI1_SSELBITSZ-1:0];

		// read data goes back into the held lane, rest zero
		assign m_pi1_data_o = PI1_MARCHBITSZ'(s_pi1_data_i) << (hold_lane * PI1_SARCHBITSZ);

	end else begin : gen_pass

		// equal widths, plain wires
		assign s_pi1_addr_o = m_pi1_addr_i;
		assign s_pi1_data_o = m_pi1_data_i;
		assign s_pi1_sel_o  = m_pi1_sel_i;
		assign m_pi1_data_o = s_pi1_data_i;

	end endgenerate

endmodule

`default_nettype wire

// File: source/pi1_byte_addr.sv
// ========================================
// word address plus byte selects to byte address
// ========================================

`timescale 1ns/10ps
`default_nettype none

module pi1_byte_addr
	import pi1_pkg::*;
(
	input  wire logic [PI1_MADDRBITSZ-1:0] addr_i,
	input  wire logic [PI1_MSELBITSZ-1:0]  sel_i,
	output logic      [PI1_MARCHBITSZ-1:0] addr_o
);

	logic [PI1_MBYTEBITSZ-1:0] byte_idx;

	// priority encoder, lowest set select wins
	always_comb begin
		byte_idx = '0;
		for (int i = PI1_MSELBITSZ - 1; i >= 0; i--) begin
			if (sel_i[i])
				byte_idx = PI1_MBYTEBITSZ'(i);
		end
	end

	// no select set leaves the offset at zero
	assign addr_o = {addr_i, byte_idx};

endmodule

`default_nettype wire

// File: source/pi1_pkg.sv
// ========================================
// PI1 bus widths, op codes and memory size
// ========================================

`default_nettype none

package pi1_pkg;

	// ========================================
	// data and select widths
	// ========================================
	localparam int PI1_MARCHBITSZ = 64; // master side
	localparam int PI1_SARCHBITSZ = 32; // slave side

	localparam int PI1_MSELBITSZ = PI1_MARCHBITSZ / 8;
	localparam int PI1_SSELBITSZ = PI1_SARCHBITSZ / 8;

	// byte offset bits inside one word
	localparam int PI1_MBYTEBITSZ = $clog2(PI1_MSELBITSZ);
	localparam int PI1_SBYTEBITSZ = $clog2(PI1_SSELBITSZ);

	// word address widths
	localparam int PI1_MADDRBITSZ = PI1_MARCHBITSZ - PI1_MBYTEBITSZ;
	localparam int PI1_SADDRBITSZ = PI1_SARCHBITSZ - PI1_SBYTEBITSZ;

	// byte address bits that pick the slave lane
	localparam int PI1_LANEBITSZ = PI1_MBYTEBITSZ - PI1_SBYTEBITSZ;

	// ========================================
	// op codes
	// ========================================
	localparam int PI1_OPBITSZ = 2;

	localparam logic [PI1_OPBITSZ-1:0] PI1_OP_NOP = 2'd0;
	localparam logic [PI1_OPBITSZ-1:0] PI1_OP_WR  = 2'd1;
	localparam logic [PI1_OPBITSZ-1:0] PI1_OP_RD  = 2'd2;
	localparam logic [PI1_OPBITSZ-1:0] PI1_OP_RW  = 2'd3; // atomic swap

	// ========================================
	// on-chip memory
	// ========================================
	localparam int PI1_MEM_WORDS     = 256;
	localparam int PI1_MEM_ADDRBITSZ = $clog2(PI1_MEM_WORDS);
	localparam int PI1_MEM_BYTES     = PI1_MEM_WORDS * PI1_SSELBITSZ;

endpackage

`default_nettype wire
